/* pixPkg.sv */
package pixPkg;

	// Frame memory geometry
	localparam int DATA_W    = 32;
	localparam int MEM_DEPTH = 256;
	localparam int ADDR_W    = 8;

	// Pixel formats as seen on the format select input
	typedef enum logic [1:0] {
		fmt4Bit  = 2'd0,
		fmt8Bit  = 2'd1,
		fmt24Bit = 2'd2,
		fmt15Bit = 2'd3
	} pixFormatE;

	// Arbiter phases on the shared memory bus
	typedef enum logic [1:0] {
		arbIdle   = 2'd0,
		arbSetup  = 2'd1,
		arbAccess = 2'd2
	} arbStateE;

endpackage

/* apbIf.sv */
`timescale 1ns/1ns

interface apbIf;
	import pixPkg::*;

	logic [ADDR_W-1:0] paddr;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [DATA_W-1:0] pwdata;
	logic [DATA_W-1:0] prdata;
	logic              pready;

	modport requester (
		output paddr, psel, penable, pwrite, pwdata,
		input  prdata, pready
	);

	modport completer (
		input  paddr, psel, penable, pwrite, pwdata,
		output prdata, pready
	);

endinterface

/* pixelPacker.sv */
`timescale 1ns/1ns

module pixelPacker (
	input  logic                      i_clk,
	input  logic                      i_nrst,
	input  logic                      i_newFrame,
	input  logic                      i_pixAccept,
	input  pixPkg::pixFormatE         i_format,
	input  logic                      i_setBit15,
	input  logic [7:0]                i_r,
	input  logic [7:0]                i_g,
	input  logic [7:0]                i_b,
	output logic                      o_wordValid,
	output logic [pixPkg::DATA_W-1:0] o_packedWord
);
	import pixPkg::*;

	logic [2:0]        pixCount;
	logic [DATA_W-1:0] stage0;
	logic [DATA_W-1:0] stage1;
	logic [DATA_W-1:0] val0;
	logic [DATA_W-1:0] val1;
	logic [7:0]        nibEn0;
	logic [7:0]        nibEn1;
	logic [15:0]       px15;
	logic              wordDone;
	logic              useStage1;
	logic              selStage1;

	// 5-5-5 colour with the mask bit in the LSB
	assign px15 = {i_r[7:3], i_g[7:3], i_b[7:3], i_setBit15};

	// Nibble enables pick the slots the current pixel lands in
	always_comb begin
		val0      = '0;
		val1      = '0;
		nibEn0    = '0;
		nibEn1    = '0;
		wordDone  = 1'b0;
		useStage1 = 1'b0;
		case (i_format)
			fmt4Bit: begin
				val0     = {8{i_r[7:4]}};
				nibEn0   = 8'h80 >> pixCount;
				wordDone = (pixCount == 3'd7);
			end
			fmt8Bit: begin
				val0     = {4{i_r}};
				nibEn0   = 8'hC0 >> {pixCount[1:0], 1'b0};
				wordDone = (pixCount[1:0] == 2'd3);
			end
			fmt15Bit: begin
				val0     = {2{px15}};
				nibEn0   = pixCount[0] ? 8'h0F : 8'hF0;
				wordDone = pixCount[0];
			end
			fmt24Bit: begin
				// Four pixels rotate through three words, the middle one in stage1
				case (pixCount[1:0])
					2'd0: begin
						val0   = {i_r, i_g, i_b, 8'h00};
						nibEn0 = 8'hFC;
					end
					2'd1: begin
						val0   = {24'h000000, i_r};
						nibEn0 = 8'h03;
						val1   = {i_g, i_b, 16'h0000};
						nibEn1 = 8'hF0;
					end
					2'd2: begin
						val0      = {i_b, 24'h000000};
						nibEn0    = 8'hC0;
						val1      = {16'h0000, i_r, i_g};
						nibEn1    = 8'h0F;
						useStage1 = 1'b1;
					end
					default: begin
						val0   = {8'h00, i_r, i_g, i_b};
						nibEn0 = 8'h3F;
					end
				endcase
				wordDone = (pixCount[1:0] != 2'd0);
			end
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (!i_nrst) begin
			pixCount    <= '0;
			o_wordValid <= 1'b0;
			selStage1   <= 1'b0;
		end else begin
			o_wordValid <= i_pixAccept && wordDone;
			if (i_newFrame)
				pixCount <= '0;
			else if (i_pixAccept)
				pixCount <= pixCount + 3'd1;
			if (i_pixAccept)
				selStage1 <= useStage1;
		end
	end

	// Staging words, overwritten slot by slot as pixels arrive
	always_ff @(posedge i_clk) begin
		if (i_pixAccept) begin
			for (int k = 0; k < 8; k++) begin
				if (nibEn0[k])
					stage0[4*k +: 4] <= val0[4*k +: 4];
				if (nibEn1[k])
					stage1[4*k +: 4] <= val1[4*k +: 4];
			end
		end
	end

	assign o_packedWord = selStage1 ? stage1 : stage0;

endmodule

/* packWriter.sv */
`timescale 1ns/1ns

module packWriter (
	input  logic                      i_clk,
	input  logic                      i_nrst,
	input  logic                      i_newFrame,
	input  logic [pixPkg::ADDR_W-1:0] i_baseAddr,
	input  logic                      i_wordValid,
	input  logic [pixPkg::DATA_W-1:0] i_packedWord,
	output logic                      o_pixReady,
	apbIf.requester                   wrBus
);
	import pixPkg::*;

	logic [DATA_W-1:0] wordBuf [2];
	logic              pushPtr;
	logic              popPtr;
	logic [1:0]        fill;
	logic [1:0]        fillNext;
	logic [ADDR_W-1:0] wrAddr;
	logic              sel;
	logic              enable;
	logic              done;

	assign done     = sel && enable && wrBus.pready;
	assign fillNext = fill + {1'b0, i_wordValid} - {1'b0, done};

	always_ff @(posedge i_clk) begin
		if (!i_nrst) begin
			fill    <= '0;
			pushPtr <= 1'b0;
			popPtr  <= 1'b0;
			wrAddr  <= '0;
			sel     <= 1'b0;
			enable  <= 1'b0;
		end else begin
			fill <= fillNext;
			if (i_wordValid)
				pushPtr <= ~pushPtr;
			if (done)
				popPtr <= ~popPtr;
			if (i_newFrame)
				wrAddr <= i_baseAddr;
			else if (done)
				wrAddr <= wrAddr + ADDR_W'(1);
			// Go straight to the next setup when another word waits
			if (done) begin
				sel    <= (fillNext != 2'd0);
				enable <= 1'b0;
			end else if (sel) begin
				enable <= 1'b1;
			end else if (fill != 2'd0) begin
				sel <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_wordValid)
			wordBuf[pushPtr] <= i_packedWord;
	end

	// Only an idle, empty writer can take pixels, so one burst of two words always fits
	assign o_pixReady    = (fill == 2'd0) && !sel;

	assign wrBus.psel    = sel;
	assign wrBus.penable = enable;
	assign wrBus.pwrite  = 1'b1;
	assign wrBus.paddr   = wrAddr;
	assign wrBus.pwdata  = wordBuf[popPtr];

endmodule

/* apbArbiter.sv */
`timescale 1ns/1ns

module apbArbiter (
	input  logic    i_clk,
	input  logic    i_nrst,
	apbIf.completer wrBus,
	apbIf.completer hostBus,
	apbIf.requester memBus
);
	import pixPkg::*;

	arbStateE state;
	logic     grantHost;
	logic     prioHost;
	logic     pickHost;
	logic     xferDone;

	// Host wins if it asks alone, or if both ask and it holds priority
	assign pickHost = hostBus.psel && (!wrBus.psel || prioHost);
	assign xferDone = (state == arbAccess) && memBus.pready;

	always_ff @(posedge i_clk) begin
		if (!i_nrst) begin
			state     <= arbIdle;
			grantHost <= 1'b0;
			prioHost  <= 1'b0;
		end else begin
			case (state)
				arbIdle: begin
					if (wrBus.psel || hostBus.psel) begin
						grantHost <= pickHost;
						state     <= arbSetup;
					end
				end
				arbSetup: begin
					// Access starts once the granted side is in its own access phase
					if (grantHost ? hostBus.penable : wrBus.penable)
						state <= arbAccess;
				end
				arbAccess: begin
					if (memBus.pready) begin
						// Served side drops to low priority
						prioHost <= !grantHost;
						state    <= arbIdle;
					end
				end
				default: state <= arbIdle;
			endcase
		end
	end

	assign memBus.psel    = (state != arbIdle);
	assign memBus.penable = (state == arbAccess);
	assign memBus.paddr   = grantHost ? hostBus.paddr : wrBus.paddr;
	assign memBus.pwrite  = grantHost ? hostBus.pwrite : wrBus.pwrite;
	assign memBus.pwdata  = grantHost ? hostBus.pwdata : wrBus.pwdata;

	// Response goes back to the granted side only
	assign wrBus.pready    = xferDone && !grantHost;
	assign hostBus.pready  = xferDone && grantHost;
	assign wrBus.prdata    = grantHost ? '0 : memBus.prdata;
	assign hostBus.prdata  = grantHost ? memBus.prdata : '0;

endmodule

/* frameMem.sv */
`timescale 1ns/1ns

module frameMem (
	input  logic    i_clk,
	input  logic    i_nrst,
	apbIf.completer memBus
);
	import pixPkg::*;

	logic [DATA_W-1:0] mem [MEM_DEPTH];
	logic [DATA_W-1:0] rdata;
	logic              readyQ;
	logic              setupPhase;

	assign setupPhase = memBus.psel && !memBus.penable;

	// Ready follows every setup cycle, so each access lasts one cycle
	always_ff @(posedge i_clk) begin
		if (!i_nrst)
			readyQ <= 1'b0;
		else
			readyQ <= setupPhase;
	end

	always_ff @(posedge i_clk) begin
		if (setupPhase)
			rdata <= mem[memBus.paddr];
		if (memBus.psel && memBus.penable && memBus.pwrite)
			mem[memBus.paddr] <= memBus.pwdata;
	end

	assign memBus.prdata = rdata;
	assign memBus.pready = readyQ;

endmodule

/* pixelSubsys.sv */
`timescale 1ns/1ns

module pixelSubsys (
	input  logic                      i_clk,
	input  logic                      i_nrst,
	input  logic                      i_newFrame,
	input  logic [pixPkg::ADDR_W-1:0] i_baseAddr,
	input  pixPkg::pixFormatE         i_format,
	input  logic                      i_setBit15,
	input  logic                      i_pixValid,
	input  logic [7:0]                i_r,
	input  logic [7:0]                i_g,
	input  logic [7:0]                i_b,
	output logic                      o_pixReady,
	input  logic                      i_hostSel,
	input  logic                      i_hostEnable,
	input  logic [pixPkg::ADDR_W-1:0] i_hostAddr,
	output logic [pixPkg::DATA_W-1:0] o_hostRdata,
	output logic                      o_hostReady
);
	import pixPkg::*;

	logic              pixAccept;
	logic              wordValid;
	logic [DATA_W-1:0] packedWord;

	apbIf wrBus ();
	apbIf hostBus ();
	apbIf memBus ();

	assign pixAccept = i_pixValid && o_pixReady;

	// Host side is read only
	assign hostBus.psel    = i_hostSel;
	assign hostBus.penable = i_hostEnable;
	assign hostBus.paddr   = i_hostAddr;
	assign hostBus.pwrite  = 1'b0;
	assign hostBus.pwdata  = '0;
	assign o_hostRdata     = hostBus.prdata;
	assign o_hostReady     = hostBus.pready;

	pixelPacker pixelPacker_inst (
		.i_clk        (i_clk),
		.i_nrst       (i_nrst),
		.i_newFrame   (i_newFrame),
		.i_pixAccept  (pixAccept),
		.i_format     (i_format),
		.i_setBit15   (i_setBit15),
		.i_r          (i_r),
		.i_g          (i_g),
		.i_b          (i_b),
		.o_wordValid  (wordValid),
		.o_packedWord (packedWord)
	);

	packWriter packWriter_inst (
		.i_clk        (i_clk),
		.i_nrst       (i_nrst),
		.i_newFrame   (i_newFrame),
		.i_baseAddr   (i_baseAddr),
		.i_wordValid  (wordValid),
		.i_packedWord (packedWord),
		.o_pixReady   (o_pixReady),
		.wrBus        (wrBus.requester)
	);

	apbArbiter apbArbiter_inst (
		.i_clk   (i_clk),
		.i_nrst  (i_nrst),
		.wrBus   (wrBus.completer),
		.hostBus (hostBus.completer),
		.memBus  (memBus.requester)
	);

	frameMem frameMem_inst (
		.i_clk  (i_clk),
		.i_nrst (i_nrst),
		.memBus (memBus.completer)
	);

endmodule

/* tbChecker.sv */
`timescale 1ns/1ns

module tbChecker (
	input logic                      i_clk,
	input logic                      i_hostReady,
	input logic [pixPkg::ADDR_W-1:0] i_hostAddr,
	input logic [pixPkg::DATA_W-1:0] i_hostRdata
);
	import pixPkg::*;

	// Expected frame memory contents, filled in as frames are planned
	logic [DATA_W-1:0] expMem [MEM_DEPTH];
	logic              expKnown [MEM_DEPTH] = '{default: 1'b0};
	string             testName;
	int                testNum    = 0;
	int                reads      = 0;
	int                mismatches = 0;
	int                strays     = 0;
	int                problems   = 0;
	int                readsAtStart;
	int                errsAtStart;

	// A completed host read is stable here, half a cycle before its closing edge
	always @(negedge i_clk) begin
		if (i_hostReady) begin
			reads++;
			if (!expKnown[i_hostAddr]) begin
				$display("Host read of address %02h, which no frame has written", i_hostAddr);
				strays++;
			end else if (i_hostRdata !== expMem[i_hostAddr]) begin
				$display("FAIL at %0t ns: address %02h read %08h, expected %08h",
					$time, i_hostAddr, i_hostRdata, expMem[i_hostAddr]);
				mismatches++;
			end
		end
	end

	task automatic expectWord(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		expMem[addr]   = data;
		expKnown[addr] = 1'b1;
	endtask

	task automatic startTest(input string name);
		testNum++;
		testName     = name;
		readsAtStart = reads;
		errsAtStart  = mismatches + strays + problems;
	endtask

	task automatic reportProblem(input string msg);
		$display("Test %0d %s: %s", testNum, testName, msg);
		problems++;
	endtask

	task automatic endTest(input int expReads);
		int seen;
		int errs;
		seen = reads - readsAtStart;
		if (seen != expReads)
			reportProblem($sformatf("expected %0d host reads but saw %0d", expReads, seen));
		errs = mismatches + strays + problems - errsAtStart;
		$display("Test %0d %s: %0d reads, %0d errors", testNum, testName, seen, errs);
	endtask

	task automatic printCounts();
		$display("Totals: %0d tests, %0d reads, %0d mismatches, %0d other errors",
			testNum, reads, mismatches, strays + problems);
	endtask

	function automatic int failures();
		return mismatches + strays + problems;
	endfunction

endmodule

/* tbPixelSubsys.sv */
`timescale 1ns/1ns

module tbPixelSubsys;
	import pixPkg::*;

	typedef logic [23:0]       pixQ [$];
	typedef logic [DATA_W-1:0] wordQ [$];

	localparam int TOTAL_PIXELS   = 112;
	localparam int TOTAL_READS    = 84;
	localparam int TIMEOUT_CYCLES = 4 * (TOTAL_PIXELS + TOTAL_READS) + 600;

	logic              clk;
	logic              nrst;
	logic              newFrame;
	logic [ADDR_W-1:0] baseAddr;
	pixFormatE         format;
	logic              setBit15;
	logic              pixValid;
	logic [7:0]        pixR;
	logic [7:0]        pixG;
	logic [7:0]        pixB;
	logic              pixReady;
	logic              hostSel;
	logic              hostEnable;
	logic [ADDR_W-1:0] hostAddr;
	logic [DATA_W-1:0] hostRdata;
	logic              hostReady;
	int                cycles = 0;
	int                stalls = 0;

	pixelSubsys pixelSubsys_inst (
		.i_clk        (clk),
		.i_nrst       (nrst),
		.i_newFrame   (newFrame),
		.i_baseAddr   (baseAddr),
		.i_format     (format),
		.i_setBit15   (setBit15),
		.i_pixValid   (pixValid),
		.i_r          (pixR),
		.i_g          (pixG),
		.i_b          (pixB),
		.o_pixReady   (pixReady),
		.i_hostSel    (hostSel),
		.i_hostEnable (hostEnable),
		.i_hostAddr   (hostAddr),
		.o_hostRdata  (hostRdata),
		.o_hostReady  (hostReady)
	);

	tbChecker tbChecker_inst (
		.i_clk       (clk),
		.i_hostReady (hostReady),
		.i_hostAddr  (hostAddr),
		.i_hostRdata (hostRdata)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// Expected words built as a bit stream with the earliest pixel in the top bits
	function automatic wordQ packFrame(input pixFormatE fmt, input logic mask, input pixQ pixels);
		wordQ        words;
		logic [63:0] acc;
		logic [63:0] shifted;
		logic [7:0]  r;
		logic [7:0]  g;
		logic [7:0]  b;
		int          nbits;
		acc   = '0;
		nbits = 0;
		foreach (pixels[i]) begin
			{r, g, b} = pixels[i];
			case (fmt)
				fmt4Bit: begin
					acc = {acc[59:0], r[7:4]};
					nbits += 4;
				end
				fmt8Bit: begin
					acc = {acc[55:0], r};
					nbits += 8;
				end
				fmt15Bit: begin
					acc = {acc[47:0], r[7:3], g[7:3], b[7:3], mask};
					nbits += 16;
				end
				default: begin
					acc = {acc[39:0], r, g, b};
					nbits += 24;
				end
			endcase
			if (nbits >= DATA_W) begin
				shifted = acc >> (nbits - DATA_W);
				words.push_back(shifted[DATA_W-1:0]);
				nbits -= DATA_W;
			end
		end
		return words;
	endfunction

	// Writer is idle once its last word has left the buffer
	task automatic waitWriterIdle();
		repeat (2) @(negedge clk);
		while (!pixReady)
			@(negedge clk);
	endtask

	task automatic sendPixels(input pixQ pixels);
		int idx;
		idx = 0;
		while (idx < pixels.size()) begin
			@(negedge clk);
			pixValid = 1'b1;
			{pixR, pixG, pixB} = pixels[idx];
			// Ready is registered, so its value now holds through the next edge
			if (pixReady)
				idx++;
			else
				stalls++;
		end
		@(negedge clk);
		pixValid = 1'b0;
	endtask

	task automatic runFrame(input pixFormatE fmt, input logic mask,
			input logic [ADDR_W-1:0] base, input int nPix);
		pixQ         pixels;
		wordQ        words;
		logic [31:0] rnd;
		repeat (nPix) begin
			rnd = $urandom();
			pixels.push_back(rnd[23:0]);
		end
		words = packFrame(fmt, mask, pixels);
		foreach (words[k])
			tbChecker_inst.expectWord(base + ADDR_W'(k), words[k]);
		@(negedge clk);
		format   = fmt;
		setBit15 = mask;
		baseAddr = base;
		newFrame = 1'b1;
		@(negedge clk);
		newFrame = 1'b0;
		sendPixels(pixels);
		waitWriterIdle();
	endtask

	task automatic hostRead(input logic [ADDR_W-1:0] addr);
		@(negedge clk);
		hostSel    = 1'b1;
		hostEnable = 1'b0;
		hostAddr   = addr;
		@(negedge clk);
		hostEnable = 1'b1;
		while (!hostReady)
			@(negedge clk);
	endtask

	// Back-to-back reads cycling through span words from base
	task automatic readRange(input logic [ADDR_W-1:0] base, input int span, input int count);
		for (int k = 0; k < count; k++)
			hostRead(base + ADDR_W'(k % span));
		@(negedge clk);
		hostSel    = 1'b0;
		hostEnable = 1'b0;
	endtask

	initial begin
		void'($urandom(32'h7b0bea4a));
		nrst       = 1'b0;
		newFrame   = 1'b0;
		baseAddr   = '0;
		format     = fmt4Bit;
		setBit15   = 1'b0;
		pixValid   = 1'b0;
		pixR       = '0;
		pixG       = '0;
		pixB       = '0;
		hostSel    = 1'b0;
		hostEnable = 1'b0;
		hostAddr   = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;

		tbChecker_inst.startTest("4-bit grey");
		runFrame(fmt4Bit, 1'b0, 8'h00, 16);
		readRange(8'h00, 2, 2);
		tbChecker_inst.endTest(2);

		tbChecker_inst.startTest("8-bit grey");
		runFrame(fmt8Bit, 1'b0, 8'h10, 16);
		readRange(8'h10, 4, 4);
		tbChecker_inst.endTest(4);

		tbChecker_inst.startTest("15-bit rgb");
		runFrame(fmt15Bit, 1'b1, 8'h20, 8);
		runFrame(fmt15Bit, 1'b0, 8'h24, 8);
		readRange(8'h20, 8, 8);
		tbChecker_inst.endTest(8);

		tbChecker_inst.startTest("24-bit rgb");
		runFrame(fmt24Bit, 1'b0, 8'h30, 8);
		readRange(8'h30, 6, 6);
		tbChecker_inst.endTest(6);

		// Second frame wraps from the top of memory over the first frame's words
		tbChecker_inst.startTest("addresses");
		runFrame(fmt8Bit, 1'b0, 8'h80, 16);
		runFrame(fmt24Bit, 1'b0, 8'hFE, 8);
		readRange(8'h80, 4, 4);
		readRange(8'hFE, 6, 6);
		readRange(8'h10, 4, 4);
		readRange(8'h20, 8, 8);
		readRange(8'h30, 6, 6);
		tbChecker_inst.endTest(28);

		tbChecker_inst.startTest("back-pressure");
		stalls = 0;
		fork
			runFrame(fmt15Bit, 1'b1, 8'h40, 32);
			readRange(8'h20, 8, 20);
		join
		readRange(8'h40, 16, 16);
		if (stalls == 0)
			tbChecker_inst.reportProblem("pixel ready never dropped while pixels were offered");
		tbChecker_inst.endTest(36);

		tbChecker_inst.printCounts();
		if (tbChecker_inst.failures() == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* pixelSubsys.f */
pixPkg.sv
apbIf.sv
pixelPacker.sv
packWriter.sv
apbArbiter.sv
frameMem.sv
pixelSubsys.sv
tbChecker.sv
tbPixelSubsys.sv

/* Makefile */
TOOL       = verilator
TOP        = tbPixelSubsys
FILELIST   = pixelSubsys.f
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
